// File: lsu_pkg.sv
package lsu_pkg;

    // lane count, scaled down from the full 64-wide wavefront
    localparam int num_lanes = 4;

    typedef logic [31:0] word_t;
    typedef logic [num_lanes-1:0][31:0] lane_vec_t;
    typedef logic [num_lanes-1:0] exec_mask_t;
    typedef logic [1:0] lane_idx_t;
    typedef logic [5:0] wfid_t;
    typedef logic [11:0] gpr_field_t;
    typedef logic [8:0] sgpr_addr_t;
    typedef logic [9:0] vgpr_addr_t;
    typedef logic [15:0] imm_t;

    // wavefront id in the upper bits, lane number in the lower two
    typedef logic [7:0] mem_tag_t;

    typedef enum logic [7:0] {
        s_load_dword       = 8'h00,
        buffer_load_dword  = 8'h0c,
        ds_write_b32       = 8'h0d,
        buffer_store_dword = 8'h1c,
        ds_read_b32        = 8'h36
    } lsu_op_e;

    typedef enum logic [2:0] {
        idle,
        operand,
        request,
        wait_ack,
        writeback
    } mgr_state_e;

    typedef struct packed {
        lsu_op_e    opcode;
        wfid_t      wfid;
        gpr_field_t src1;
        gpr_field_t src2;
        gpr_field_t src3;
        gpr_field_t dest;
        imm_t       imm;
        imm_t       lds_base;
        word_t      pc;
    } lsu_issue_t;

    // gm_or_lds is set for LDS accesses
    typedef struct packed {
        logic       is_read;
        logic       is_write;
        logic       is_scalar;
        logic       gm_or_lds;
        logic       valid_op;
        vgpr_addr_t dest;
        wfid_t      wfid;
    } lsu_decoded_t;

    typedef struct packed {
        logic       sgpr_rd_en;
        sgpr_addr_t sgpr_addr;
        logic       vgpr1_rd_en;
        vgpr_addr_t vgpr1_addr;
        logic       vgpr2_rd_en;
        vgpr_addr_t vgpr2_addr;
    } gpr_rd_req_t;

    typedef struct packed {
        word_t    addr;
        word_t    wr_data;
        mem_tag_t tag;
        logic     gm_or_lds;
    } mem_req_t;

    typedef struct packed {
        logic       en;
        vgpr_addr_t addr;
        lane_vec_t  data;
        exec_mask_t mask;
    } vgpr_wr_t;

    typedef struct packed {
        logic       en;
        sgpr_addr_t addr;
        word_t      data;
    } sgpr_wr_t;

endpackage

// File: lsu_opcode_decoder.sv
`timescale 1ns/1ps

module lsu_opcode_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_select,
    input  lsu_pkg::lsu_issue_t  issue,
    output lsu_pkg::lsu_decoded_t decoded,
    output logic                 decoded_valid,
    output lsu_pkg::gpr_rd_req_t gpr_rd
);

    lsu_pkg::lsu_decoded_t dec_next;
    logic vector_op;

    // classify the opcode as it arrives from issue
    always_comb begin
        dec_next = '0;
        dec_next.dest = issue.dest[9:0];
        dec_next.wfid = issue.wfid;
        dec_next.valid_op = 1'b1;
        case (issue.opcode)
            lsu_pkg::s_load_dword: begin
                dec_next.is_read = 1'b1;
                dec_next.is_scalar = 1'b1;
            end
            lsu_pkg::buffer_load_dword: begin
                dec_next.is_read = 1'b1;
            end
            lsu_pkg::buffer_store_dword: begin
                dec_next.is_write = 1'b1;
            end
            lsu_pkg::ds_read_b32: begin
                dec_next.is_read = 1'b1;
                dec_next.gm_or_lds = 1'b1;
            end
            lsu_pkg::ds_write_b32: begin
                dec_next.is_write = 1'b1;
                dec_next.gm_or_lds = 1'b1;
            end
            default: begin
                // unknown op, nothing is read and no memory is touched
                dec_next.valid_op = 1'b0;
            end
        endcase
    end

    assign vector_op = dec_next.valid_op && !dec_next.is_scalar;

    // read enables are high only in the cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            decoded_valid <= 1'b0;
            gpr_rd <= '0;
        end else begin
            decoded_valid <= issue_select;
            gpr_rd.sgpr_rd_en <= issue_select && dec_next.valid_op;
            gpr_rd.vgpr1_rd_en <= issue_select && vector_op;
            gpr_rd.vgpr2_rd_en <= issue_select && vector_op && dec_next.is_write;
            gpr_rd.sgpr_addr <= issue.src1[8:0];
            // offset vector on port 1, store data on port 2
            gpr_rd.vgpr1_addr <= issue.src2[9:0];
            gpr_rd.vgpr2_addr <= issue.src3[9:0];
        end
    end

    // descriptor is held until the next issue
    always_ff @(posedge clk) begin
        if (issue_select) begin
            decoded <= dec_next;
        end
    end

endmodule

// File: lsu_addr_calculator.sv
`timescale 1ns/1ps

module lsu_addr_calculator (
    input  lsu_pkg::lsu_decoded_t decoded,
    input  lsu_pkg::imm_t         imm,
    input  lsu_pkg::imm_t         lds_base,
    input  lsu_pkg::word_t        sgpr_data,
    input  lsu_pkg::lane_vec_t    vgpr_offset,
    output lsu_pkg::lane_vec_t    lane_addr
);

    lsu_pkg::word_t imm_ext;
    lsu_pkg::word_t lds_base_ext;

    // both immediates are unsigned byte offsets
    assign imm_ext = lsu_pkg::word_t'(imm);
    assign lds_base_ext = lsu_pkg::word_t'(lds_base);

    always_comb begin
        lane_addr = '0;
        if (decoded.is_scalar) begin
            // scalar load uses a single address in lane 0
            lane_addr[0] = sgpr_data + imm_ext;
        end else begin
            for (int i = 0; i < lsu_pkg::num_lanes; i++) begin
                if (decoded.gm_or_lds) begin
                    // LDS space does not see the buffer base
                    lane_addr[i] = lds_base_ext + vgpr_offset[i] + imm_ext;
                end else begin
                    lane_addr[i] = sgpr_data + vgpr_offset[i] + imm_ext;
                end
            end
        end
    end

endmodule

// File: lsu_op_manager.sv
`timescale 1ns/1ps

module lsu_op_manager (
    input  logic                  clk,
    input  logic                  rst,
    input  lsu_pkg::lsu_decoded_t decoded,
    input  logic                  decoded_valid,
    input  lsu_pkg::exec_mask_t   exec_mask,
    input  lsu_pkg::lane_vec_t    lane_addr,
    input  lsu_pkg::lane_vec_t    store_data,
    input  logic                  mem_ack,
    input  lsu_pkg::mem_tag_t     mem_tag_resp,
    input  lsu_pkg::word_t        mem_rd_data,
    output logic                  mem_rd_en,
    output logic                  mem_wr_en,
    output lsu_pkg::mem_req_t     mem_req,
    output lsu_pkg::vgpr_wr_t     vgpr_wr,
    output lsu_pkg::sgpr_wr_t     sgpr_wr,
    output logic                  issue_ready,
    output logic                  lsu_done,
    output lsu_pkg::wfid_t        done_wfid
);

    lsu_pkg::mgr_state_e state;
    lsu_pkg::exec_mask_t exec_q;
    // lanes still waiting for their request
    lsu_pkg::exec_mask_t pend_q;
    lsu_pkg::lane_idx_t  cur_lane;
    lsu_pkg::lane_idx_t  next_lane;
    lsu_pkg::lane_vec_t  addr_q;
    lsu_pkg::lane_vec_t  data_q;
    lsu_pkg::lane_vec_t  rd_data_q;
    lsu_pkg::mem_tag_t   cur_tag;
    logic                do_wb;
    logic                no_work;
    logic                resp_ok;

    function automatic lsu_pkg::lane_idx_t lowest_lane(input lsu_pkg::exec_mask_t m);
        lsu_pkg::lane_idx_t idx;
        idx = '0;
        for (int i = lsu_pkg::num_lanes - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = lsu_pkg::lane_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign next_lane = lowest_lane(pend_q);
    assign cur_tag = {decoded.wfid, cur_lane};
    // responses carrying another tag are dropped
    assign resp_ok = mem_ack && (mem_tag_resp == cur_tag);
    assign no_work = !decoded.valid_op || (!decoded.is_scalar && exec_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::idle;
            pend_q <= '0;
            cur_lane <= '0;
        end else begin
            case (state)
                lsu_pkg::idle: begin
                    if (decoded_valid) begin
                        state <= lsu_pkg::operand;
                    end
                end
                lsu_pkg::operand: begin
                    state <= no_work ? lsu_pkg::writeback : lsu_pkg::request;
                    pend_q <= decoded.is_scalar ? lsu_pkg::exec_mask_t'(1) : exec_q;
                end
                lsu_pkg::request: begin
                    state <= lsu_pkg::wait_ack;
                    cur_lane <= next_lane;
                    pend_q[next_lane] <= 1'b0;
                end
                lsu_pkg::wait_ack: begin
                    // a slow memory just keeps us here
                    if (resp_ok) begin
                        state <= (pend_q == '0) ? lsu_pkg::writeback : lsu_pkg::request;
                    end
                end
                lsu_pkg::writeback: begin
                    state <= lsu_pkg::idle;
                end
                default: begin
                    state <= lsu_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // mask is sampled in the issue cycle
        if (issue_ready) begin
            exec_q <= exec_mask;
        end
        // register data from the read ports is valid here
        if (state == lsu_pkg::operand) begin
            addr_q <= lane_addr;
            data_q <= store_data;
            do_wb <= !no_work && decoded.is_read;
        end
        if (state == lsu_pkg::wait_ack && resp_ok && decoded.is_read) begin
            rd_data_q[cur_lane] <= mem_rd_data;
        end
    end

    assign mem_rd_en = (state == lsu_pkg::request) && decoded.is_read;
    assign mem_wr_en = (state == lsu_pkg::request) && decoded.is_write;
    assign mem_req.addr = addr_q[next_lane];
    assign mem_req.wr_data = data_q[next_lane];
    assign mem_req.tag = {decoded.wfid, next_lane};
    assign mem_req.gm_or_lds = decoded.gm_or_lds;

    assign vgpr_wr.en = (state == lsu_pkg::writeback) && do_wb && !decoded.is_scalar;
    assign vgpr_wr.addr = decoded.dest;
    assign vgpr_wr.data = rd_data_q;
    assign vgpr_wr.mask = exec_q;

    // scalar destination is the low part of the dest field
    assign sgpr_wr.en = (state == lsu_pkg::writeback) && do_wb && decoded.is_scalar;
    assign sgpr_wr.addr = decoded.dest[8:0];
    assign sgpr_wr.data = rd_data_q[0];

    assign lsu_done = (state == lsu_pkg::writeback);
    assign done_wfid = decoded.wfid;
    assign issue_ready = (state == lsu_pkg::idle) && !decoded_valid;

endmodule

// File: lsu.sv
`timescale 1ns/1ps

module lsu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_select,
    input  lsu_pkg::lsu_issue_t  issue,
    input  lsu_pkg::exec_mask_t  exec_mask,
    output logic                 issue_ready,
    output lsu_pkg::gpr_rd_req_t gpr_rd,
    input  lsu_pkg::word_t       sgpr_rd_data,
    input  lsu_pkg::lane_vec_t   vgpr_rd_data1,
    input  lsu_pkg::lane_vec_t   vgpr_rd_data2,
    output logic                 mem_rd_en,
    output logic                 mem_wr_en,
    output lsu_pkg::mem_req_t    mem_req,
    input  logic                 mem_ack,
    input  lsu_pkg::mem_tag_t    mem_tag_resp,
    input  lsu_pkg::word_t       mem_rd_data,
    output lsu_pkg::vgpr_wr_t    vgpr_wr,
    output lsu_pkg::sgpr_wr_t    sgpr_wr,
    output logic                 rf_wr_req,
    output logic                 lsu_done,
    output lsu_pkg::wfid_t       done_wfid
);

    lsu_pkg::lsu_decoded_t decoded;
    logic                  decoded_valid;
    lsu_pkg::lane_vec_t    lane_addr;
    lsu_pkg::imm_t         imm_d1;
    lsu_pkg::imm_t         imm_d2;
    lsu_pkg::imm_t         lds_base_d1;
    lsu_pkg::imm_t         lds_base_d2;

    // two stages so the offsets line up with the register read data
    always_ff @(posedge clk) begin
        imm_d1 <= issue.imm;
        imm_d2 <= imm_d1;
        lds_base_d1 <= issue.lds_base;
        lds_base_d2 <= lds_base_d1;
    end

    lsu_opcode_decoder u_decoder (
        .clk           (clk),
        .rst           (rst),
        .issue_select  (issue_select),
        .issue         (issue),
        .decoded       (decoded),
        .decoded_valid (decoded_valid),
        .gpr_rd        (gpr_rd)
    );

    lsu_addr_calculator u_addr_calc (
        .decoded     (decoded),
        .imm         (imm_d2),
        .lds_base    (lds_base_d2),
        .sgpr_data   (sgpr_rd_data),
        .vgpr_offset (vgpr_rd_data1),
        .lane_addr   (lane_addr)
    );

    lsu_op_manager u_op_manager (
        .clk           (clk),
        .rst           (rst),
        .decoded       (decoded),
        .decoded_valid (decoded_valid),
        .exec_mask     (exec_mask),
        .lane_addr     (lane_addr),
        .store_data    (vgpr_rd_data2),
        .mem_ack       (mem_ack),
        .mem_tag_resp  (mem_tag_resp),
        .mem_rd_data   (mem_rd_data),
        .mem_rd_en     (mem_rd_en),
        .mem_wr_en     (mem_wr_en),
        .mem_req       (mem_req),
        .vgpr_wr       (vgpr_wr),
        .sgpr_wr       (sgpr_wr),
        .issue_ready   (issue_ready),
        .lsu_done      (lsu_done),
        .done_wfid     (done_wfid)
    );

    assign rf_wr_req = vgpr_wr.en | sgpr_wr.en;

endmodule

// File: lsu_properties.sv
`timescale 1ns/1ps

module lsu_properties (
    input logic                clk,
    input logic                rst,
    input logic                issue_select,
    input logic                issue_ready,
    input logic                mem_rd_en,
    input logic                mem_wr_en,
    input logic                mem_ack,
    input logic                lsu_done,
    input lsu_pkg::vgpr_wr_t   vgpr_wr,
    input lsu_pkg::sgpr_wr_t   sgpr_wr
);

    logic outstanding;
    logic busy;

    // track one request in flight and one instruction in progress
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
            busy <= 1'b0;
        end else begin
            if (mem_rd_en || mem_wr_en) begin
                outstanding <= 1'b1;
            end else if (mem_ack) begin
                outstanding <= 1'b0;
            end
            if (issue_select) begin
                busy <= 1'b1;
            end else if (lsu_done) begin
                busy <= 1'b0;
            end
        end
    end

    single_request: assert property (@(posedge clk) disable iff (rst)
        (mem_rd_en || mem_wr_en) |-> !outstanding)
        else $error("memory request sent while a response is outstanding");

    ready_low_while_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !issue_ready)
        else $error("issue_ready high between issue and done");

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!vgpr_wr.en && !sgpr_wr.en && !lsu_done))
        else $error("write enable or done active right after reset");

endmodule

bind lsu lsu_properties u_props (
    .clk          (clk),
    .rst          (rst),
    .issue_select (issue_select),
    .issue_ready  (issue_ready),
    .mem_rd_en    (mem_rd_en),
    .mem_wr_en    (mem_wr_en),
    .mem_ack      (mem_ack),
    .lsu_done     (lsu_done),
    .vgpr_wr      (vgpr_wr),
    .sgpr_wr      (sgpr_wr)
);

// File: tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

    typedef struct packed {
        lsu_pkg::lane_vec_t  addr;
        lsu_pkg::lane_vec_t  data;
        lsu_pkg::exec_mask_t mask;
    } ref_result_t;

    logic                  clk;
    logic                  rst;
    logic                  issue_select;
    lsu_pkg::lsu_issue_t   issue;
    lsu_pkg::exec_mask_t   exec_mask;
    logic                  issue_ready;
    lsu_pkg::gpr_rd_req_t  gpr_rd;
    lsu_pkg::word_t        sgpr_rd_data;
    lsu_pkg::lane_vec_t    vgpr_rd_data1;
    lsu_pkg::lane_vec_t    vgpr_rd_data2;
    logic                  mem_rd_en;
    logic                  mem_wr_en;
    lsu_pkg::mem_req_t     mem_req;
    logic                  mem_ack;
    lsu_pkg::mem_tag_t     mem_tag_resp;
    lsu_pkg::word_t        mem_rd_data;
    lsu_pkg::vgpr_wr_t     vgpr_wr;
    lsu_pkg::sgpr_wr_t     sgpr_wr;
    logic                  rf_wr_req;
    logic                  lsu_done;
    lsu_pkg::wfid_t        done_wfid;

    // register file and memory models
    lsu_pkg::word_t        sgpr_file [512];
    lsu_pkg::lane_vec_t    vgpr_file [1024];
    lsu_pkg::gpr_rd_req_t  rd_req_q;
    logic                  done_prev;

    // expected responses in order
    lsu_pkg::mem_req_t     exp_req_q [$];
    logic                  exp_wr_q [$];
    lsu_pkg::vgpr_wr_t     exp_vgpr_q [$];
    lsu_pkg::sgpr_wr_t     exp_sgpr_q [$];
    lsu_pkg::wfid_t        exp_done_q [$];
    string                 cur_test;

    lsu_pkg::word_t        stim_rng;
    lsu_pkg::word_t        mem_rng;
    logic                  pend;
    int                    pend_delay;
    lsu_pkg::mem_tag_t     pend_tag;
    lsu_pkg::word_t        pend_data;
    lsu_pkg::wfid_t        next_wfid;

    lsu UUT (
        .clk           (clk),
        .rst           (rst),
        .issue_select  (issue_select),
        .issue         (issue),
        .exec_mask     (exec_mask),
        .issue_ready   (issue_ready),
        .gpr_rd        (gpr_rd),
        .sgpr_rd_data  (sgpr_rd_data),
        .vgpr_rd_data1 (vgpr_rd_data1),
        .vgpr_rd_data2 (vgpr_rd_data2),
        .mem_rd_en     (mem_rd_en),
        .mem_wr_en     (mem_wr_en),
        .mem_req       (mem_req),
        .mem_ack       (mem_ack),
        .mem_tag_resp  (mem_tag_resp),
        .mem_rd_data   (mem_rd_data),
        .vgpr_wr       (vgpr_wr),
        .sgpr_wr       (sgpr_wr),
        .rf_wr_req     (rf_wr_req),
        .lsu_done      (lsu_done),
        .done_wfid     (done_wfid)
    );

    always #2 clk = ~clk;

    function automatic lsu_pkg::word_t lcg_step(input lsu_pkg::word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // fold the upper half in since the low LCG bits are weak
    function lsu_pkg::word_t next_rand();
        stim_rng = lcg_step(stim_rng);
        return stim_rng ^ (stim_rng >> 16);
    endfunction

    function lsu_pkg::exec_mask_t rand_mask();
        return lsu_pkg::exec_mask_t'(next_rand());
    endfunction

    // memory read data pattern
    function automatic lsu_pkg::word_t mem_pattern(input lsu_pkg::word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
    endfunction

    function automatic ref_result_t ref_model(input lsu_pkg::lsu_op_e op,
                                              input lsu_pkg::word_t base,
                                              input lsu_pkg::lane_vec_t offs,
                                              input lsu_pkg::lane_vec_t sdata,
                                              input lsu_pkg::exec_mask_t mask,
                                              input lsu_pkg::imm_t imm,
                                              input lsu_pkg::imm_t lds_base);
        ref_result_t r;
        r = '0;
        case (op)
            lsu_pkg::s_load_dword: begin
                r.mask = 4'b0001;
                r.addr[0] = base + {16'h0, imm};
                r.data[0] = mem_pattern(r.addr[0]);
            end
            lsu_pkg::buffer_load_dword, lsu_pkg::buffer_store_dword,
            lsu_pkg::ds_read_b32, lsu_pkg::ds_write_b32: begin
                r.mask = mask;
                for (int i = 0; i < lsu_pkg::num_lanes; i++) begin
                    if (op == lsu_pkg::ds_read_b32 || op == lsu_pkg::ds_write_b32) begin
                        r.addr[i] = {16'h0, lds_base} + offs[i] + {16'h0, imm};
                    end else begin
                        r.addr[i] = base + offs[i] + {16'h0, imm};
                    end
                    if (op == lsu_pkg::buffer_store_dword || op == lsu_pkg::ds_write_b32) begin
                        r.data[i] = sdata[i];
                    end else begin
                        r.data[i] = mem_pattern(r.addr[i]);
                    end
                end
            end
            default: begin
                r.mask = '0;
            end
        endcase
        return r;
    endfunction

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic fail_run(input string why);
        $display("ERROR: %s", why);
        stop_run();
    endtask

    task automatic check_mem_req(input string name, input lsu_pkg::mem_req_t exp,
                                 input lsu_pkg::mem_req_t act, input logic is_wr);
        if (exp.addr !== act.addr || exp.tag !== act.tag ||
            exp.gm_or_lds !== act.gm_or_lds || (is_wr && exp.wr_data !== act.wr_data)) begin
            $write("[FAIL] %s mem_req expected addr=%h data=%h tag=%h lds=%b", name,
                   exp.addr, exp.wr_data, exp.tag, exp.gm_or_lds);
            $display(" actual addr=%h data=%h tag=%h lds=%b",
                     act.addr, act.wr_data, act.tag, act.gm_or_lds);
            stop_run();
        end
    endtask

    task automatic check_vgpr_wr(input string name, input lsu_pkg::vgpr_wr_t exp,
                                 input lsu_pkg::vgpr_wr_t act);
        logic bad;
        bad = (exp.addr !== act.addr) || (exp.mask !== act.mask);
        // inactive lanes carry stale data
        for (int i = 0; i < lsu_pkg::num_lanes; i++) begin
            if (exp.mask[i] && exp.data[i] !== act.data[i]) begin
                bad = 1'b1;
            end
        end
        if (bad) begin
            $write("[FAIL] %s vgpr_wr expected addr=%h mask=%b data=%h", name,
                   exp.addr, exp.mask, exp.data);
            $display(" actual addr=%h mask=%b data=%h",
                     act.addr, act.mask, act.data);
            stop_run();
        end
    endtask

    task automatic check_sgpr_wr(input string name, input lsu_pkg::sgpr_wr_t exp,
                                 input lsu_pkg::sgpr_wr_t act);
        if (exp.addr !== act.addr || exp.data !== act.data) begin
            $display("[FAIL] %s sgpr_wr expected addr=%h data=%h actual addr=%h data=%h",
                     name, exp.addr, exp.data, act.addr, act.data);
            stop_run();
        end
    endtask

    task automatic check_wfid(input string name, input lsu_pkg::wfid_t exp,
                              input lsu_pkg::wfid_t act);
        if (exp !== act) begin
            $display("[FAIL] %s done_wfid expected %0d actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    // register file, memory and response checks run on the falling edge
    always @(negedge clk) begin : models
        lsu_pkg::mem_req_t exp_req;
        logic              exp_wr;
        if (!rst) begin
            // register file answers in the cycle after the read enable
            if (rd_req_q.sgpr_rd_en) begin
                sgpr_rd_data = sgpr_file[rd_req_q.sgpr_addr];
            end
            if (rd_req_q.vgpr1_rd_en) begin
                vgpr_rd_data1 = vgpr_file[rd_req_q.vgpr1_addr];
            end
            if (rd_req_q.vgpr2_rd_en) begin
                vgpr_rd_data2 = vgpr_file[rd_req_q.vgpr2_addr];
            end
            rd_req_q = gpr_rd;
            if (done_prev && !issue_ready) begin
                fail_run("issue_ready not high in the cycle after done");
            end
            done_prev = lsu_done;
            mem_ack = 1'b0;
            if (pend) begin
                if (pend_delay <= 1) begin
                    mem_ack = 1'b1;
                    mem_tag_resp = pend_tag;
                    mem_rd_data = pend_data;
                    pend = 1'b0;
                end else begin
                    pend_delay--;
                end
            end
            if (mem_rd_en || mem_wr_en) begin
                if (pend) fail_run("memory request sent while another is outstanding");
                if (exp_req_q.size() == 0) fail_run("memory request that was not expected");
                exp_req = exp_req_q.pop_front();
                exp_wr = exp_wr_q.pop_front();
                if (mem_wr_en !== exp_wr || mem_rd_en === mem_wr_en) begin
                    fail_run("memory request has the wrong read or write direction");
                end
                check_mem_req(cur_test, exp_req, mem_req, exp_wr);
                pend = 1'b1;
                pend_tag = mem_req.tag;
                pend_data = mem_pattern(mem_req.addr);
                mem_rng = lcg_step(mem_rng);
                pend_delay = 1 + int'(mem_rng[23:16] % 8'd6);
            end
            if (vgpr_wr.en) begin
                if (exp_vgpr_q.size() == 0) fail_run("vector register write that was not expected");
                check_vgpr_wr(cur_test, exp_vgpr_q.pop_front(), vgpr_wr);
            end
            if (sgpr_wr.en) begin
                if (exp_sgpr_q.size() == 0) fail_run("scalar register write that was not expected");
                check_sgpr_wr(cur_test, exp_sgpr_q.pop_front(), sgpr_wr);
            end
            if (rf_wr_req !== (vgpr_wr.en || sgpr_wr.en)) begin
                fail_run("rf_wr_req does not follow the register write enables");
            end
            if (lsu_done) begin
                if (exp_done_q.size() == 0) fail_run("done pulse that was not expected");
                check_wfid(cur_test, exp_done_q.pop_front(), done_wfid);
            end
        end
    end

    // issue one instruction; called on a falling edge
    task automatic run_op(input string name, input lsu_pkg::lsu_op_e op,
                          input lsu_pkg::exec_mask_t mask);
        int                  waited;
        lsu_pkg::lsu_issue_t iss;
        ref_result_t         r;
        lsu_pkg::mem_req_t   req;
        lsu_pkg::vgpr_wr_t   vw;
        lsu_pkg::sgpr_wr_t   sw;
        logic                is_st;
        logic                is_ld;
        waited = 0;
        while (!issue_ready) begin
            @(negedge clk);
            waited++;
            if (waited > 300) fail_run("issue_ready did not return after done");
        end
        iss = '0;
        iss.opcode = op;
        iss.wfid = next_wfid;
        iss.src1 = lsu_pkg::gpr_field_t'(next_rand() % 512);
        iss.src2 = lsu_pkg::gpr_field_t'(next_rand() & 32'h3fe);
        iss.src3 = iss.src2 | 12'h001;
        iss.dest = lsu_pkg::gpr_field_t'(next_rand() & 32'h3ff);
        iss.imm = lsu_pkg::imm_t'(next_rand());
        iss.lds_base = lsu_pkg::imm_t'(next_rand());
        iss.pc = next_rand();
        sgpr_file[iss.src1[8:0]] = next_rand();
        for (int i = 0; i < lsu_pkg::num_lanes; i++) begin
            vgpr_file[iss.src2[9:0]][i] = next_rand();
            vgpr_file[iss.src3[9:0]][i] = next_rand();
        end
        r = ref_model(op, sgpr_file[iss.src1[8:0]], vgpr_file[iss.src2[9:0]],
                      vgpr_file[iss.src3[9:0]], mask, iss.imm, iss.lds_base);
        is_st = (op == lsu_pkg::buffer_store_dword || op == lsu_pkg::ds_write_b32);
        is_ld = (op == lsu_pkg::buffer_load_dword || op == lsu_pkg::ds_read_b32);
        for (int i = 0; i < lsu_pkg::num_lanes; i++) begin
            if (r.mask[i]) begin
                req.addr = r.addr[i];
                req.wr_data = is_st ? r.data[i] : '0;
                req.tag = {next_wfid, lsu_pkg::lane_idx_t'(i)};
                req.gm_or_lds = (op == lsu_pkg::ds_read_b32 || op == lsu_pkg::ds_write_b32);
                exp_req_q.push_back(req);
                exp_wr_q.push_back(is_st);
            end
        end
        if (is_ld && r.mask != '0) begin
            vw.en = 1'b1;
            vw.addr = iss.dest[9:0];
            vw.data = r.data;
            vw.mask = r.mask;
            exp_vgpr_q.push_back(vw);
        end
        if (op == lsu_pkg::s_load_dword) begin
            sw.en = 1'b1;
            sw.addr = iss.dest[8:0];
            sw.data = r.data[0];
            exp_sgpr_q.push_back(sw);
        end
        exp_done_q.push_back(next_wfid);
        cur_test = name;
        issue = iss;
        exec_mask = mask;
        issue_select = 1'b1;
        @(negedge clk);
        issue_select = 1'b0;
        // issue fields and mask only count together with issue_select
        issue = '0;
        exec_mask = ~mask;
        if (issue_ready) fail_run("issue_ready still high the cycle after issue");
        next_wfid++;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_done_q.size() != 0 || !issue_ready) begin
            @(negedge clk);
            waited++;
            if (waited > 500) fail_run("instructions did not complete in time");
        end
        if (exp_req_q.size() != 0 || exp_vgpr_q.size() != 0 || exp_sgpr_q.size() != 0) begin
            fail_run("expected requests or register writes never appeared");
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        issue_select = 1'b0;
        issue = '0;
        exec_mask = '0;
        sgpr_rd_data = '0;
        vgpr_rd_data1 = '0;
        vgpr_rd_data2 = '0;
        mem_ack = 1'b0;
        mem_tag_resp = '0;
        mem_rd_data = '0;
        stim_rng = 32'h0298_0661;
        mem_rng = 32'h0298_0661 ^ 32'h5555_aaaa;
        pend = 1'b0;
        pend_delay = 0;
        next_wfid = '0;
        rd_req_q = '0;
        done_prev = 1'b0;
        cur_test = "reset";
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (!issue_ready || mem_rd_en || mem_wr_en || lsu_done || rf_wr_req ||
            gpr_rd.sgpr_rd_en || gpr_rd.vgpr1_rd_en || gpr_rd.vgpr2_rd_en) begin
            fail_run("outputs not at their reset values after reset");
        end
        repeat (8) run_op("buffer_load", lsu_pkg::buffer_load_dword, rand_mask());
        wait_idle();
        repeat (6) run_op("buffer_store", lsu_pkg::buffer_store_dword, rand_mask());
        wait_idle();
        repeat (4) begin
            run_op("ds_read", lsu_pkg::ds_read_b32, rand_mask());
            run_op("ds_write", lsu_pkg::ds_write_b32, rand_mask());
        end
        wait_idle();
        repeat (3) run_op("scalar_load", lsu_pkg::s_load_dword, rand_mask());
        wait_idle();
        run_op("empty_mask_load", lsu_pkg::buffer_load_dword, 4'b0000);
        run_op("empty_mask_store", lsu_pkg::ds_write_b32, 4'b0000);
        run_op("unknown_op", lsu_pkg::lsu_op_e'(8'h7f), 4'b1111);
        wait_idle();
        // in a mixed back-to-back stream the done order follows issue order
        run_op("mixed", lsu_pkg::buffer_load_dword, 4'b1010);
        run_op("mixed", lsu_pkg::s_load_dword, 4'b0000);
        run_op("mixed", lsu_pkg::lsu_op_e'(8'h3f), 4'b0110);
        run_op("mixed", lsu_pkg::buffer_store_dword, 4'b1111);
        run_op("mixed", lsu_pkg::ds_read_b32, 4'b0001);
        wait_idle();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: src.f
lsu_pkg.sv
lsu_opcode_decoder.sv
lsu_addr_calculator.sv
lsu_op_manager.sv
lsu.sv
lsu_properties.sv
tb_lsu.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lsu -f src.f -Mdir obj_dir -o tb_lsu

# the simulator exits non-zero on a fatal check, so keep the output either way
out=$(./obj_dir/tb_lsu 2>&1) || true
echo "$out"

if grep -q "Simulation finished: PASS" <<< "$out"; then
    exit 0
else
    exit 1
fi
